// ==== vga_pkg.sv ====
`default_nettype none

package vga_pkg;

  ////////////////////
  // Display timing
  ////////////////////

  // Horizontal, in pixels
  localparam int H_TOTAL      = 1056;
  localparam int H_VISIBLE    = 800;
  localparam int H_SYNC_START = 840;
  localparam int H_SYNC_END   = 968;

  // Vertical, in lines
  localparam int V_TOTAL      = 628;
  localparam int V_VISIBLE    = 600;
  localparam int V_SYNC_START = 601;
  localparam int V_SYNC_END   = 605;

  ////////////////////
  // Block row geometry
  ////////////////////

  localparam int BLOCKS_N     = 7;
  localparam int BLOCK_WIDTH  = 80;
  localparam int BLOCK_HEIGHT = 25;
  localparam int OFFSET_Y     = 100;

  // Row centred on the screen, shifted one pixel left
  localparam int START_X = ((H_VISIBLE - (BLOCKS_N * BLOCK_WIDTH)) / 2) - 1;

  localparam int N_LAYERS      = 2;
  localparam int LAYER_LATENCY = 3;

  ////////////////////
  // Texture colours
  ////////////////////

  localparam logic [11:0] TRANSPARENT   = 12'hFFF;
  localparam logic [11:0] GROUND_RGB    = 12'h840;
  localparam logic [11:0] GROUND_STRIPE = 12'h620;
  localparam logic [11:0] SKY_RGB       = 12'h4AF;

  typedef enum logic [1:0] {
    BLOCK_EMPTY  = 2'd0,
    BLOCK_GROUND = 2'd1,
    BLOCK_SKY    = 2'd2
  } block_kind_t;

  typedef struct packed {
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic [11:0] rgb;
  } vga_bus_t;

  // Bit k of each map belongs to block k
  typedef struct packed {
    logic [6:0]  block_map;
    logic [6:0]  block_sky;
    logic [11:0] ypos;
  } layer_cfg_t;

  typedef struct packed {
    logic [6:0] rel_y;
    logic [6:0] rel_x;
  } tex_addr_t;

endpackage

`default_nettype wire

// ==== vga_timing.sv ====
`default_nettype none

module vga_timing
(
  input  wire                pclk,
  input  wire                rst,
  output vga_pkg::vga_bus_t  bus
);

  logic [10:0] hcount;
  logic [10:0] vcount;
  logic [10:0] hcount_nxt;
  logic [10:0] vcount_nxt;
  logic        hsync;
  logic        vsync;
  logic        hsync_nxt;
  logic        vsync_nxt;

  ////////////////////
  // Counters
  ////////////////////

  always_comb
  begin
    hcount_nxt = hcount + 11'd1;
    vcount_nxt = vcount;
    if (hcount == 11'(vga_pkg::H_TOTAL - 1))
    begin
      hcount_nxt = '0;
      if (vcount == 11'(vga_pkg::V_TOTAL - 1))
        vcount_nxt = '0;
      else
        vcount_nxt = vcount + 11'd1;
    end
  end

  // Syncs follow the counts they will be registered with
  assign hsync_nxt = (hcount_nxt >= 11'(vga_pkg::H_SYNC_START)) &&
                     (hcount_nxt <  11'(vga_pkg::H_SYNC_END));
  assign vsync_nxt = (vcount_nxt >= 11'(vga_pkg::V_SYNC_START)) &&
                     (vcount_nxt <  11'(vga_pkg::V_SYNC_END));

  always_ff @(posedge pclk)
  begin
    if (rst)
    begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
    end
    else
    begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hsync  <= hsync_nxt;
      vsync  <= vsync_nxt;
    end
  end

  // Black background
  always_comb
  begin
    bus.hcount = hcount;
    bus.vcount = vcount;
    bus.hsync  = hsync;
    bus.vsync  = vsync;
    bus.rgb    = 12'h000;
  end

  ////////////////////
  // Checks
  ////////////////////

  a_hsync_window: assert property (
    @(posedge pclk) disable iff (rst)
    hsync |-> (hcount >= 11'(vga_pkg::H_SYNC_START)) &&
              (hcount <  11'(vga_pkg::H_SYNC_END))
  );

endmodule

`default_nettype wire

// ==== block_texture.sv ====
`default_nettype none

module block_texture
(
  input  wire                 pclk,
  input  wire                 rst,
  input  vga_pkg::tex_addr_t  addr,
  output logic [11:0]         ground_rgb,
  output logic [11:0]         sky_rgb
);

  logic [11:0] ground_nxt;
  logic [11:0] sky_nxt;
  logic [6:0]  diag;

  ////////////////////
  // Ground
  ////////////////////

  // Dark stripe every eighth column
  assign ground_nxt = (addr.rel_x[2:0] == 3'd0) ? vga_pkg::GROUND_STRIPE
                                                : vga_pkg::GROUND_RGB;

  ////////////////////
  // Sky
  ////////////////////

  // Diagonal bands, every other one see-through
  assign diag    = addr.rel_x + addr.rel_y;
  assign sky_nxt = diag[3] ? vga_pkg::TRANSPARENT : vga_pkg::SKY_RGB;

  // One clock read latency, like a block RAM
  always_ff @(posedge pclk)
  begin
    if (rst)
    begin
      ground_rgb <= '0;
      sky_rgb    <= '0;
    end
    else
    begin
      ground_rgb <= ground_nxt;
      sky_rgb    <= sky_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== draw_layer.sv ====
`default_nettype none

module draw_layer
(
  input  wire                  pclk,
  input  wire                  rst,
  input  wire                  layer_en,
  input  vga_pkg::layer_cfg_t  cfg,
  input  vga_pkg::vga_bus_t    bus_in,
  output vga_pkg::vga_bus_t    bus_out
);

  logic [11:0]           vpos;
  logic                  in_band;
  vga_pkg::block_kind_t  kind_nxt;
  vga_pkg::tex_addr_t    addr_nxt;

  vga_pkg::block_kind_t  kind_q1;
  vga_pkg::block_kind_t  kind_q2;
  vga_pkg::tex_addr_t    addr_q;
  vga_pkg::vga_bus_t     bus_q1;
  vga_pkg::vga_bus_t     bus_q2;

  logic [11:0]           ground_rgb;
  logic [11:0]           sky_rgb;
  logic [11:0]           tex_rgb;
  logic                  opaque;
  vga_pkg::vga_bus_t     bus_nxt;

  ////////////////////
  // Block lookup
  ////////////////////

  // Band test in 13 bits so ypos near the top cannot wrap
  assign vpos    = 12'(bus_in.vcount) + 12'(vga_pkg::OFFSET_Y);
  assign in_band = ({1'b0, vpos} >= {1'b0, cfg.ypos}) &&
                   ({1'b0, vpos} <  ({1'b0, cfg.ypos} + 13'(vga_pkg::BLOCK_HEIGHT)));

  always_comb
  begin
    kind_nxt = vga_pkg::BLOCK_EMPTY;
    addr_nxt = '0;
    for (int k = 0; k < vga_pkg::BLOCKS_N; k++)
    begin
      if (in_band &&
          (bus_in.hcount >= 11'(vga_pkg::START_X + k * vga_pkg::BLOCK_WIDTH)) &&
          (bus_in.hcount <  11'(vga_pkg::START_X + (k + 1) * vga_pkg::BLOCK_WIDTH)))
      begin
        addr_nxt.rel_x = 7'(bus_in.hcount -
                            11'(vga_pkg::START_X + k * vga_pkg::BLOCK_WIDTH));
        addr_nxt.rel_y = 7'(vpos - cfg.ypos);
        if (layer_en && cfg.block_map[k])
          kind_nxt = cfg.block_sky[k] ? vga_pkg::BLOCK_SKY : vga_pkg::BLOCK_GROUND;
      end
    end
  end

  ////////////////////
  // Pipeline
  ////////////////////

  always_ff @(posedge pclk)
  begin
    if (rst)
    begin
      kind_q1 <= vga_pkg::BLOCK_EMPTY;
      kind_q2 <= vga_pkg::BLOCK_EMPTY;
      addr_q  <= '0;
      bus_q1  <= '0;
      bus_q2  <= '0;
    end
    else
    begin
      kind_q1 <= kind_nxt;
      addr_q  <= addr_nxt;
      bus_q1  <= bus_in;
      // Texture read happens here
      kind_q2 <= kind_q1;
      bus_q2  <= bus_q1;
    end
  end

  block_texture u_texture (
    .pclk       (pclk),
    .rst        (rst),
    .addr       (addr_q),
    .ground_rgb (ground_rgb),
    .sky_rgb    (sky_rgb)
  );

  ////////////////////
  // Overlay
  ////////////////////

  assign tex_rgb = (kind_q2 == vga_pkg::BLOCK_SKY) ? sky_rgb : ground_rgb;
  assign opaque  = (kind_q2 != vga_pkg::BLOCK_EMPTY) && (tex_rgb != vga_pkg::TRANSPARENT);

  always_comb
  begin
    bus_nxt     = bus_q2;
    bus_nxt.rgb = opaque ? tex_rgb : bus_q2.rgb;
  end

  always_ff @(posedge pclk)
  begin
    if (rst)
      bus_out <= '0;
    else
      bus_out <= bus_nxt;
  end

  // Nothing drawn for an empty block or a disabled layer
  a_pass_through: assert property (
    @(posedge pclk) disable iff (rst)
    ($past(kind_q2 == vga_pkg::BLOCK_EMPTY) || $past(!layer_en, vga_pkg::LAYER_LATENCY))
      |-> (bus_out.rgb == $past(bus_q2.rgb))
  );

endmodule

`default_nettype wire

// ==== vga_out.sv ====
`default_nettype none

module vga_out
(
  input  wire                pclk,
  input  wire                rst,
  input  vga_pkg::vga_bus_t  bus_in,
  output logic               hsync,
  output logic               vsync,
  output logic [11:0]        rgb,
  output logic [10:0]        hcount,
  output logic [10:0]        vcount
);

  logic visible;

  assign visible = (bus_in.hcount < 11'(vga_pkg::H_VISIBLE)) &&
                   (bus_in.vcount < 11'(vga_pkg::V_VISIBLE));

  always_ff @(posedge pclk)
  begin
    if (rst)
    begin
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      rgb    <= '0;
      hcount <= '0;
      vcount <= '0;
    end
    else
    begin
      hsync  <= bus_in.hsync;
      vsync  <= bus_in.vsync;
      // Blanking outside the active area
      rgb    <= visible ? bus_in.rgb : 12'h000;
      hcount <= bus_in.hcount;
      vcount <= bus_in.vcount;
    end
  end

endmodule

`default_nettype wire

// ==== layer_stack.sv ====
`default_nettype none

module layer_stack
(
  input  wire                          pclk,
  input  wire                          rst,
  input  wire [vga_pkg::N_LAYERS-1:0]  layer_en,
  input  vga_pkg::layer_cfg_t          layer_cfg [0:vga_pkg::N_LAYERS-1],
  output logic                         hsync,
  output logic                         vsync,
  output logic [11:0]                  rgb,
  output logic [10:0]                  hcount,
  output logic [10:0]                  vcount
);

  // Stage 0 from the timing generator, stage i+1 from layer i
  vga_pkg::vga_bus_t bus [0:vga_pkg::N_LAYERS];

  vga_timing u_timing (
    .pclk (pclk),
    .rst  (rst),
    .bus  (bus[0])
  );

  ////////////////////
  // Layer chain
  ////////////////////

  // Later layers paint over earlier ones
  for (genvar i = 0; i < vga_pkg::N_LAYERS; i++)
  begin : g_layer
    draw_layer u_layer (
      .pclk     (pclk),
      .rst      (rst),
      .layer_en (layer_en[i]),
      .cfg      (layer_cfg[i]),
      .bus_in   (bus[i]),
      .bus_out  (bus[i+1])
    );
  end

  vga_out u_out (
    .pclk   (pclk),
    .rst    (rst),
    .bus_in (bus[vga_pkg::N_LAYERS]),
    .hsync  (hsync),
    .vsync  (vsync),
    .rgb    (rgb),
    .hcount (hcount),
    .vcount (vcount)
  );

endmodule

`default_nettype wire

// ==== tb_layer_stack.sv ====
`default_nettype none

module tb_layer_stack;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HALF     = 2;
  localparam int CLK_PERIOD   = 2 * CLK_HALF;
  localparam int RESET_CYCLES = 2;
  localparam int TABLE_LEN    = 6;

  localparam longint FRAME_NS =
    longint'(vga_pkg::H_TOTAL) * longint'(vga_pkg::V_TOTAL) * longint'(CLK_PERIOD);
  localparam longint WATCHDOG_NS = longint'(TABLE_LEN) * FRAME_NS + 2 * FRAME_NS;

  // One row of the stimulus table
  typedef struct packed {
    logic [vga_pkg::N_LAYERS-1:0]                       layer_en;
    vga_pkg::layer_cfg_t [vga_pkg::N_LAYERS-1:0]        cfg;
    logic [7:0]                                         frames;
  } test_entry_t;

  logic                          pclk;
  logic                          rst;
  logic [vga_pkg::N_LAYERS-1:0]  layer_en;
  vga_pkg::layer_cfg_t           layer_cfg [0:vga_pkg::N_LAYERS-1];
  logic                          hsync;
  logic                          vsync;
  logic [11:0]                   rgb;
  logic [10:0]                   hcount;
  logic [10:0]                   vcount;

  test_entry_t  test_table [0:TABLE_LEN-1];
  test_entry_t  cur_entry;
  logic [15:0]  lfsr_state;
  logic [10:0]  exp_hcount;
  logic [10:0]  exp_vcount;
  logic         counting;

  layer_stack u_dut (
    .pclk      (pclk),
    .rst       (rst),
    .layer_en  (layer_en),
    .layer_cfg (layer_cfg),
    .hsync     (hsync),
    .vsync     (vsync),
    .rgb       (rgb),
    .hcount    (hcount),
    .vcount    (vcount)
  );

  always #(CLK_HALF) pclk = ~pclk;

  ////////////////////
  // Random source
  ////////////////////

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] nxt;
    nxt = s >> 1;
    if (s[0])
      nxt = nxt ^ 16'hB400;
    return nxt;
  endfunction

  task automatic draw_bits(input int n, output logic [11:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[10:0], lfsr_state[0]};
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [11:0] expected_rgb(input int hc, input int vc,
                                               input test_entry_t t);
    logic [11:0] color;
    logic [11:0] tex;
    int          left;
    int          top;
    int          rx;
    int          ry;
    color = 12'h000;
    if (hc >= vga_pkg::H_VISIBLE || vc >= vga_pkg::V_VISIBLE)
      return 12'h000;
    // Layer 0 first, so layer 1 lands on top
    for (int l = 0; l < vga_pkg::N_LAYERS; l++)
    begin
      top = int'(t.cfg[l].ypos);
      for (int k = 0; k < vga_pkg::BLOCKS_N; k++)
      begin
        left = vga_pkg::START_X + k * vga_pkg::BLOCK_WIDTH;
        if (t.layer_en[l] && t.cfg[l].block_map[k] &&
            hc >= left && hc < left + vga_pkg::BLOCK_WIDTH &&
            vc + vga_pkg::OFFSET_Y >= top &&
            vc + vga_pkg::OFFSET_Y < top + vga_pkg::BLOCK_HEIGHT)
        begin
          rx = hc - left;
          ry = vc + vga_pkg::OFFSET_Y - top;
          if (t.cfg[l].block_sky[k])
            tex = (((rx + ry) & 8) != 0) ? vga_pkg::TRANSPARENT : vga_pkg::SKY_RGB;
          else
            tex = ((rx & 7) == 0) ? vga_pkg::GROUND_STRIPE : vga_pkg::GROUND_RGB;
          if (tex != vga_pkg::TRANSPARENT)
            color = tex;
        end
      end
    end
    return color;
  endfunction

  // Scan position the ports should show next, one pixel per clock
  task automatic advance_count();
    if (!counting)
    begin
      // Reset words repeat (0,0) until the first real pixel arrives
      if (hcount == 11'd1)
      begin
        counting   = 1'b1;
        exp_hcount = 11'd1;
      end
    end
    else if (exp_hcount == 11'(vga_pkg::H_TOTAL - 1))
    begin
      exp_hcount = '0;
      if (exp_vcount == 11'(vga_pkg::V_TOTAL - 1))
        exp_vcount = '0;
      else
        exp_vcount = exp_vcount + 11'd1;
    end
    else
      exp_hcount = exp_hcount + 11'd1;
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_rgb(input logic [11:0] expected, input logic [11:0] actual);
    if (actual !== expected)
      stop_on_error($sformatf("Fail at %0d ns: rgb at (%0d,%0d) expected %h, got %h",
                              $time, hcount, vcount, expected, actual));
  endtask

  task automatic check_count(input string name, input logic [10:0] expected,
                             input logic [10:0] actual);
    if (actual !== expected)
      stop_on_error($sformatf("Fail at %0d ns: %s expected %0d, got %0d",
                              $time, name, expected, actual));
  endtask

  task automatic check_sync(input vga_pkg::vga_bus_t seen);
    logic exp_h;
    logic exp_v;
    exp_h = (int'(seen.hcount) >= vga_pkg::H_SYNC_START) &&
            (int'(seen.hcount) <  vga_pkg::H_SYNC_END);
    exp_v = (int'(seen.vcount) >= vga_pkg::V_SYNC_START) &&
            (int'(seen.vcount) <  vga_pkg::V_SYNC_END);
    if (seen.hsync !== exp_h)
      stop_on_error($sformatf("Fail at %0d ns: hsync at (%0d,%0d) expected %b, got %b",
                              $time, seen.hcount, seen.vcount, exp_h, seen.hsync));
    if (seen.vsync !== exp_v)
      stop_on_error($sformatf("Fail at %0d ns: vsync at (%0d,%0d) expected %b, got %b",
                              $time, seen.hcount, seen.vcount, exp_v, seen.vsync));
  endtask

  function automatic vga_pkg::vga_bus_t port_bus();
    vga_pkg::vga_bus_t b;
    b.hcount = hcount;
    b.vcount = vcount;
    b.hsync  = hsync;
    b.vsync  = vsync;
    b.rgb    = rgb;
    return b;
  endfunction

  // Outputs settle after the rising edge, so look at them on the falling one
  task automatic step_check();
    @(negedge pclk);
    advance_count();
    check_count("hcount", exp_hcount, hcount);
    check_count("vcount", exp_vcount, vcount);
    check_sync(port_bus());
    check_rgb(expected_rgb(int'(hcount), int'(vcount), cur_entry), rgb);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic apply_entry(input test_entry_t t);
    cur_entry = t;
    layer_en  = t.layer_en;
    for (int i = 0; i < vga_pkg::N_LAYERS; i++)
      layer_cfg[i] = t.cfg[i];
  endtask

  task automatic build_table();
    logic [11:0] r;
    // Both layers off although their maps are full
    test_table[0].layer_en = 2'b00;
    test_table[0].cfg[0]   = '{block_map: 7'h7F, block_sky: 7'h00, ypos: 12'd110};
    test_table[0].cfg[1]   = '{block_map: 7'h7F, block_sky: 7'h7F, ypos: 12'd110};
    // Enabled with nothing in the maps
    test_table[1].layer_en = 2'b11;
    test_table[1].cfg[0]   = '{block_map: 7'h00, block_sky: 7'h00, ypos: 12'd100};
    test_table[1].cfg[1]   = '{block_map: 7'h00, block_sky: 7'h7F, ypos: 12'd150};
    // Ground row alone
    test_table[2].layer_en = 2'b01;
    test_table[2].cfg[0]   = '{block_map: 7'h7F, block_sky: 7'h00, ypos: 12'd200};
    test_table[2].cfg[1]   = '{block_map: 7'h7F, block_sky: 7'h7F, ypos: 12'd200};
    // Sky over ground, partly overlapping
    test_table[3].layer_en = 2'b11;
    test_table[3].cfg[0]   = '{block_map: 7'h7F, block_sky: 7'h00, ypos: 12'd300};
    test_table[3].cfg[1]   = '{block_map: 7'h7F, block_sky: 7'h7F, ypos: 12'd310};
    // Random rows, one band cut by each screen edge
    for (int e = 4; e < TABLE_LEN; e++)
    begin
      test_table[e].layer_en = 2'b11;
      for (int l = 0; l < vga_pkg::N_LAYERS; l++)
      begin
        draw_bits(7, r);
        test_table[e].cfg[l].block_map = r[6:0];
        draw_bits(7, r);
        test_table[e].cfg[l].block_sky = r[6:0];
      end
    end
    draw_bits(4, r);
    test_table[4].cfg[0].ypos = 12'd80 + r;
    draw_bits(9, r);
    test_table[4].cfg[1].ypos = 12'd100 + r;
    draw_bits(4, r);
    test_table[5].cfg[0].ypos = 12'd680 + r;
    draw_bits(10, r);
    test_table[5].cfg[1].ypos = r;
    for (int e = 0; e < TABLE_LEN; e++)
      test_table[e].frames = 8'd1;
  endtask

  initial
  begin
    pclk       = 1'b0;
    rst        = 1'b1;
    lfsr_state = 16'd50;
    exp_hcount = '0;
    exp_vcount = '0;
    counting   = 1'b0;
    build_table();
    apply_entry(test_table[0]);

    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(negedge pclk);
      check_count("hcount", 11'd0, hcount);
      check_count("vcount", 11'd0, vcount);
      check_sync(port_bus());
      check_rgb(12'h000, rgb);
    end
    rst = 1'b0;

    for (int e = 0; e < TABLE_LEN; e++)
    begin
      // New settings take effect in vertical blanking
      if (e > 0)
        apply_entry(test_table[e]);
      step_check();
      while (!(hcount == 11'd0 && vcount == 11'd0))
        step_check();
      for (int f = 0; f < int'(test_table[e].frames); f++)
      begin
        step_check();
        while (!(hcount == 11'd0 && vcount == 11'(vga_pkg::V_VISIBLE)))
          step_check();
      end
    end

    // Rest of the last frame
    while (!(hcount == 11'(vga_pkg::H_TOTAL - 1) && vcount == 11'(vga_pkg::V_TOTAL - 1)))
      step_check();

    $display("Verification passed");
    $finish;
  end

  ////////////////////
  // Watchdog
  ////////////////////

  initial
  begin
    #(WATCHDOG_NS);
    stop_on_error($sformatf("Timeout after %0d ns: the test frames never completed",
                            WATCHDOG_NS));
  end

endmodule

`default_nettype wire

// ==== project.f ====
vga_pkg.sv
vga_timing.sv
block_texture.sv
draw_layer.sv
vga_out.sv
layer_stack.sv
tb_layer_stack.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_layer_stack \
  -f project.f \
  -o tb_layer_stack

./obj_dir/tb_layer_stack
